/* design/sdm_pkg.sv */
// signal analysis subsystem shared definitions
// bus register map, control word, status and measurement records
`default_nettype none

package sdm_pkg;

    localparam int period_w = 20; // period count, clk cycles
    localparam int adc_w    = 12; // adc sample width
    localparam int reg_w    = 16; // mcu bus data width
    localparam int div_w    = 12; // adc clock divisor width

    // register map, 8 bit address phase
    typedef enum logic [7:0] {
        ADDR_CTRL      = 8'd0, // rw
        ADDR_STATUS    = 8'd1, // ro
        ADDR_PERIOD_LO = 8'd2, // ro, period[15:0]
        ADDR_PERIOD_HI = 8'd3, // ro, period[19:16]
        ADDR_SAMPLE    = 8'd4, // ro, read pops next sample
        ADDR_DIVISOR   = 8'd5  // ro
    } reg_addr_e;

    // control register fields, lsb first in the word
    typedef struct packed {
        logic [11:0] reserved;
        logic        arm;         // bit 3, self clearing
        logic [1:0]  manual_gain; // bits 2:1
        logic        auto_gain;   // bit 0
    } ctrl_fields_t;

    // bus sees the raw word, datapath decodes the fields
    typedef union packed {
        logic [reg_w-1:0] raw;
        ctrl_fields_t     f;
    } ctrl_word_u;

    typedef struct packed {
        logic [9:0] reserved;
        logic [1:0] gain;          // bits 5:4
        logic       capture_busy;  // bit 3
        logic       capture_done;  // bit 2
        logic       gain_stable;   // bit 1
        logic       period_stable; // bit 0
    } status_t;

    // datapath measurements handed to the bus
    typedef struct packed {
        logic [period_w-1:0] period;
        logic [div_w-1:0]    divisor;
    } measure_t;

endpackage

`default_nettype wire

/* design/bus_regs.sv */
// mcu bus interface for the multiplexed async bus
// synchronises strobes, holds the control word and serves register reads
`timescale 1ns/10ps
`default_nettype none

module bus_regs (
    input  logic                         clk,
    input  logic                         arst_n,
    inout  wire  [sdm_pkg::reg_w-1:0]    ad,
    input  logic                         nadv,
    input  logic                         nwe,
    input  logic                         noe,
    input  sdm_pkg::status_t             status,
    input  sdm_pkg::measure_t            meas,
    input  logic [sdm_pkg::reg_w-1:0]    sample_data,
    output sdm_pkg::ctrl_word_u          ctrl,
    output logic                         arm,
    output logic                         pop
);
    import sdm_pkg::*;

    // auto gain on out of reset so the relay holds 0 until samples arrive
    localparam ctrl_fields_t ctrl_rst = '{reserved: '0, arm: 1'b0,
                                          manual_gain: 2'd0, auto_gain: 1'b1};

    logic [2:0]       nadv_q, nwe_q, noe_q; // 2 sync stages + edge stage
    logic [reg_w-1:0] ad_s1, ad_s2, ad_d;   // ad_d lines up with the edge stage
    logic             nadv_rise, wr_stb, noe_fall, rd_active;
    reg_addr_e        addr;
    ctrl_word_u       bus_word;
    logic [reg_w-1:0] rd_mux, rd_data_q;
    logic             drive_en;

    assign nadv_rise = nadv_q[1] & ~nadv_q[2];
    assign wr_stb    = nwe_q[1] & ~nwe_q[2];  // end of write strobe
    assign noe_fall  = ~noe_q[1] & noe_q[2];
    assign rd_active = ~noe_q[1];
    assign bus_word.raw = ad_d;

    // strobes idle high
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            nadv_q <= '1;
            nwe_q  <= '1;
            noe_q  <= '1;
        end else begin
            nadv_q <= {nadv_q[1:0], nadv};
            nwe_q  <= {nwe_q[1:0], nwe};
            noe_q  <= {noe_q[1:0], noe};
        end
    end

    always_ff @(posedge clk) begin
        ad_s1 <= ad;
        ad_s2 <= ad_s1;
        ad_d  <= ad_s2;
    end

    // address latch, control write, arm pulse
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            addr   <= ADDR_CTRL;
            ctrl.f <= ctrl_rst;
            arm    <= 1'b0;
        end else begin
            arm <= 1'b0;
            if (nadv_rise)
                addr <= reg_addr_e'(ad_d[7:0]);
            if (wr_stb && addr == ADDR_CTRL) begin
                ctrl.raw   <= bus_word.raw;
                ctrl.f.arm <= 1'b0;           // arm bit never stored
                arm        <= bus_word.f.arm; // single cycle
            end
        end
    end

    always_comb begin
        case (addr)
            ADDR_CTRL:      rd_mux = ctrl.raw;
            ADDR_STATUS:    rd_mux = status;
            ADDR_PERIOD_LO: rd_mux = meas.period[15:0];
            ADDR_PERIOD_HI: rd_mux = reg_w'(meas.period[period_w-1:16]);
            ADDR_SAMPLE:    rd_mux = sample_data;
            ADDR_DIVISOR:   rd_mux = reg_w'(meas.divisor);
            default:        rd_mux = '0;
        endcase
    end

    // pop advances the buffer in the same edge that captures its word
    assign pop = noe_fall && addr == ADDR_SAMPLE;

    always_ff @(posedge clk) begin
        if (noe_fall)
            rd_data_q <= rd_mux; // held for the whole read
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            drive_en <= 1'b0;
        else if (noe_fall)
            drive_en <= 1'b1;
        else if (!rd_active)
            drive_en <= 1'b0; // release after noe rises
    end

    assign ad = drive_en ? rd_data_q : 'z;

    // mcu never overlaps a write strobe with an output enable
    a_no_wr_during_rd: assert property (@(posedge clk) disable iff (!arst_n)
        !(wr_stb && rd_active))
        else $error("bus write strobe during read");

endmodule

`default_nettype wire

/* design/period_meter.sv */
// square wave period meter
// counts clk cycles between rising edges, flags consecutive matching periods
`timescale 1ns/10ps
`default_nettype none

module period_meter #(
    parameter int TOLERANCE = 4
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          signal_in,
    output logic [sdm_pkg::period_w-1:0]  period,
    output logic                          period_stable
);
    import sdm_pkg::*;

    localparam logic [period_w-1:0] max_cnt = '1;
    localparam logic [period_w-1:0] tol     = period_w'(TOLERANCE);

    logic [2:0]          sig_q;  // 2 sync stages + edge stage
    logic                rise;
    logic [period_w-1:0] cnt;
    logic [period_w-1:0] diff;   // |new - last|
    logic [1:0]          edges;  // saturates at 2

    assign rise = sig_q[1] & ~sig_q[2];
    assign diff = (cnt >= period) ? cnt - period : period - cnt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sig_q         <= '0;
            cnt           <= '0;
            edges         <= '0;
            period        <= '0;
            period_stable <= 1'b0;
        end else begin
            sig_q <= {sig_q[1:0], signal_in};
            if (rise) begin
                cnt <= period_w'(1); // edge cycle counts as 1
                if (edges != 2'd2)
                    edges <= edges + 2'd1;
                if (edges != 2'd0)
                    period <= cnt; // first count runs from reset, skip it
                // both periods must be real edge-to-edge counts
                period_stable <= (edges == 2'd2) && (cnt != max_cnt) && (diff <= tol);
            end else if (cnt != max_cnt) begin
                cnt <= cnt + 1'b1;
            end else begin
                period_stable <= 1'b0; // input stopped toggling
            end
        end
    end

    // saturated count only leaves max on a new edge
    a_cnt_saturates: assert property (@(posedge clk) disable iff (!arst_n)
        (cnt == max_cnt) |=> (cnt == max_cnt) || (cnt == period_w'(1)))
        else $error("period counter wrapped");

endmodule

`default_nettype wire

/* design/sample_clock.sv */
// adc sample clock generator
// period / 64 divisor drives adc_clk and a sample strobe and latches adc data
`timescale 1ns/10ps
`default_nettype none

module sample_clock (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic [sdm_pkg::period_w-1:0]  period,
    input  logic                          period_stable,
    output logic [sdm_pkg::div_w-1:0]     divisor,
    output logic                          sample_stb,
    output logic                          adc_clk,
    output logic                          adc_oe_n,
    input  logic [sdm_pkg::adc_w-1:0]     adc_data,
    output logic [sdm_pkg::adc_w-1:0]     sample
);
    import sdm_pkg::*;

    localparam int spp_log2 = 6; // 64 samples per period

    logic [period_w-spp_log2-1:0] quot;
    logic [div_w-1:0]             div_clamp;
    logic [div_w-1:0]             cnt;    // counts divisor-1 down to 0
    logic                         reload;

    assign quot   = period[period_w-1:spp_log2];
    assign reload = period_stable && cnt == '0;

    always_comb begin
        if (|quot[period_w-spp_log2-1:div_w])
            div_clamp = '1; // very slow input clamps to max
        else if (quot[div_w-1:0] < div_w'(2))
            div_clamp = div_w'(2); // adc_clk needs a high and a low cycle
        else
            div_clamp = quot[div_w-1:0];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            divisor    <= div_w'(2);
            cnt        <= '0;
            sample_stb <= 1'b0;
            adc_clk    <= 1'b0;
            adc_oe_n   <= 1'b1;
        end else begin
            divisor    <= div_clamp;
            sample_stb <= reload;
            adc_oe_n   <= !period_stable;
            if (!period_stable) begin
                cnt     <= '0;
                adc_clk <= 1'b0; // parked low until the period settles
            end else if (reload) begin
                cnt     <= divisor - 1'b1;
                adc_clk <= 1'b1; // rises with the strobe
            end else begin
                cnt <= cnt - 1'b1;
                if (cnt <= (divisor >> 1))
                    adc_clk <= 1'b0; // second half low, also after a divisor step
            end
        end
    end

    // word present just before adc_clk rises
    always_ff @(posedge clk) begin
        if (reload)
            sample <= adc_data;
    end

    // each strobe marks an adc_clk rise with the adc enabled
    a_stb_on_adc_rise: assert property (@(posedge clk) disable iff (!arst_n)
        sample_stb |-> !adc_oe_n && $rose(adc_clk))
        else $error("sample strobe without a stable period and an adc_clk rise");

endmodule

`default_nettype wire

/* design/capture_buffer.sv */
// adc capture buffer
// records DEPTH samples after arm, returns one per bus read
`timescale 1ns/10ps
`default_nettype none

module capture_buffer #(
    parameter int DEPTH = 1024
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        arm,
    input  logic                        sample_stb,
    input  logic [sdm_pkg::adc_w-1:0]   sample,
    input  logic                        pop,
    output logic [sdm_pkg::reg_w-1:0]   sample_data,
    output logic                        capture_busy,
    output logic                        capture_done
);
    import sdm_pkg::*;

    localparam int            aw   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [aw-1:0] last = aw'(DEPTH - 1);

    logic [adc_w-1:0] mem [DEPTH];
    logic [aw-1:0]    wr_ptr;
    logic [aw-1:0]    rd_ptr;
    logic [aw-1:0]    rd_nxt;
    logic [adc_w-1:0] rd_q;
    logic             wr_en;

    assign wr_en = capture_busy && sample_stb && !arm; // re-arm wins

    always_comb begin
        rd_nxt = rd_ptr;
        if (arm)
            rd_nxt = '0;
        else if (pop)
            rd_nxt = (rd_ptr == last) ? '0 : rd_ptr + 1'b1;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            capture_busy <= 1'b0;
            capture_done <= 1'b0;
        end else begin
            rd_ptr <= rd_nxt;
            if (arm) begin
                wr_ptr       <= '0;
                capture_busy <= 1'b1;
                capture_done <= 1'b0;
            end else if (wr_en) begin
                if (wr_ptr == last) begin
                    wr_ptr       <= '0;
                    capture_busy <= 1'b0; // full, later samples dropped
                    capture_done <= 1'b1;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
        end
    end

    // read ahead on the next pointer so popped data is ready one cycle on
    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_ptr] <= sample;
        rd_q <= mem[rd_nxt];
    end

    assign sample_data = reg_w'(rd_q); // zero extended

    a_busy_done_excl: assert property (@(posedge clk) disable iff (!arst_n)
        !(capture_busy && capture_done))
        else $error("capture busy and done together");

endmodule

`default_nettype wire

/* design/gain_control.sv */
// relay gain control
// windowed peak amplitude steps the gain, or manual gain from the control word
`timescale 1ns/10ps
`default_nettype none

module gain_control #(
    parameter int WINDOW     = 64,
    parameter int HIGH_LEVEL = 1800,
    parameter int LOW_LEVEL  = 400
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  sdm_pkg::ctrl_word_u         ctrl,
    input  logic                        sample_stb,
    input  logic [sdm_pkg::adc_w-1:0]   sample,
    output logic [1:0]                  gain,
    output logic                        gain_stable
);
    import sdm_pkg::*;

    localparam int               cw       = $clog2(WINDOW + 1);
    localparam logic [cw-1:0]    win_last = cw'(WINDOW - 1);
    localparam logic [adc_w-1:0] mid      = adc_w'(1 << (adc_w - 1)); // offset binary zero
    localparam logic [adc_w-1:0] high_c   = adc_w'(HIGH_LEVEL);
    localparam logic [adc_w-1:0] low_c    = adc_w'(LOW_LEVEL);

    logic [adc_w-1:0] mag;      // |sample - mid|
    logic [adc_w-1:0] peak;
    logic [adc_w-1:0] peak_nxt;
    logic [cw-1:0]    win_cnt;

    assign mag      = sample[adc_w-1] ? sample - mid : mid - sample;
    assign peak_nxt = (mag > peak) ? mag : peak;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            gain        <= 2'd0;
            gain_stable <= 1'b0;
            peak        <= '0;
            win_cnt     <= '0;
        end else if (!ctrl.f.auto_gain) begin
            gain        <= ctrl.f.manual_gain; // relay follows register
            gain_stable <= 1'b1;
            peak        <= '0;
            win_cnt     <= '0; // fresh window when auto returns
        end else if (sample_stb) begin
            if (win_cnt == win_last) begin
                win_cnt <= '0;
                peak    <= '0;
                if (peak_nxt > high_c && gain != 2'd0) begin
                    gain        <= gain - 2'd1; // clipping risk
                    gain_stable <= 1'b0;
                end else if (peak_nxt < low_c && gain != 2'd3) begin
                    gain        <= gain + 2'd1; // too small
                    gain_stable <= 1'b0;
                end else begin
                    gain_stable <= 1'b1;
                end
            end else begin
                win_cnt <= win_cnt + 1'b1;
                peak    <= peak_nxt;
            end
        end
    end

endmodule

`default_nettype wire

/* design/sdm_top.sv */
// signal analysis subsystem top level
// mcu bus registers around the period, sample clock, capture and gain blocks
`timescale 1ns/10ps
`default_nettype none

module sdm_top #(
    parameter int DEPTH      = 1024,
    parameter int WINDOW     = 64,
    parameter int HIGH_LEVEL = 1800,
    parameter int LOW_LEVEL  = 400,
    parameter int TOLERANCE  = 4
) (
    input  logic                        clk,
    input  logic                        arst_n,
    inout  wire  [sdm_pkg::reg_w-1:0]   ad,
    input  logic                        nadv,
    input  logic                        nwe,
    input  logic                        noe,
    input  logic [sdm_pkg::adc_w-1:0]   adc_data,
    input  logic                        signal_in,
    output logic [1:0]                  gain_ctrl,
    output logic                        adc_clk,
    output logic                        adc_oe_n
);
    import sdm_pkg::*;

    ctrl_word_u          ctrl;
    logic                arm, pop;
    logic [period_w-1:0] period;
    logic                period_stable;
    logic [div_w-1:0]    divisor;
    logic                sample_stb;
    logic [adc_w-1:0]    sample;
    logic [reg_w-1:0]    sample_data;
    logic                capture_busy, capture_done;
    logic [1:0]          gain;
    logic                gain_stable;
    status_t             status;
    measure_t            meas;

    assign status = '{reserved: '0, gain: gain, capture_busy: capture_busy,
                      capture_done: capture_done, gain_stable: gain_stable,
                      period_stable: period_stable};
    assign meas      = '{period: period, divisor: divisor};
    assign gain_ctrl = gain; // relay pins

    bus_regs bus_regs_inst (
        .clk(clk), .arst_n(arst_n), .ad(ad), .nadv(nadv), .nwe(nwe), .noe(noe),
        .status(status), .meas(meas), .sample_data(sample_data),
        .ctrl(ctrl), .arm(arm), .pop(pop)
    );

    period_meter #(.TOLERANCE(TOLERANCE)) period_meter_inst (
        .clk(clk), .arst_n(arst_n), .signal_in(signal_in),
        .period(period), .period_stable(period_stable)
    );

    sample_clock sample_clock_inst (
        .clk(clk), .arst_n(arst_n), .period(period), .period_stable(period_stable),
        .divisor(divisor), .sample_stb(sample_stb), .adc_clk(adc_clk),
        .adc_oe_n(adc_oe_n), .adc_data(adc_data), .sample(sample)
    );

    capture_buffer #(.DEPTH(DEPTH)) capture_buffer_inst (
        .clk(clk), .arst_n(arst_n), .arm(arm), .sample_stb(sample_stb),
        .sample(sample), .pop(pop), .sample_data(sample_data),
        .capture_busy(capture_busy), .capture_done(capture_done)
    );

    gain_control #(
        .WINDOW(WINDOW), .HIGH_LEVEL(HIGH_LEVEL), .LOW_LEVEL(LOW_LEVEL)
    ) gain_control_inst (
        .clk(clk), .arst_n(arst_n), .ctrl(ctrl), .sample_stb(sample_stb),
        .sample(sample), .gain(gain), .gain_stable(gain_stable)
    );

endmodule

`default_nettype wire

/* tests/sdm_tb.sv */
// testbench for the signal analysis subsystem
// mcu bus driver, square wave and adc models, assertion based checks
`timescale 1ns/10ps
`default_nettype none

module sdm_tb;
    import sdm_pkg::*;

    localparam int test_period = 1280; // square wave period, clk cycles
    localparam int exp_divisor = test_period / 64;

    // status bit positions
    localparam int st_period_stable = 0;
    localparam int st_gain_stable   = 1;
    localparam int st_capture_done  = 2;

    logic        clk;
    logic        arst_n;
    logic [15:0] ad_out;
    logic        ad_en;     // tb owns the bus when high
    logic        nadv, nwe, noe;
    logic [11:0] adc_data;
    logic        signal_in;
    logic [1:0]  gain_ctrl;
    logic        adc_clk, adc_oe_n;
    wire  [15:0] ad;

    int          sq_period;  // 0 parks the square wave low
    logic        full_scale; // adc model mode
    logic        watch_fs;   // gain must not rise while set

    logic [15:0] rd;
    logic [15:0] prev_sample;
    int          gap;

    assign ad = ad_en ? ad_out : 'z;

    sdm_top #(.DEPTH(64), .WINDOW(16)) sdm_top_inst (
        .clk(clk), .arst_n(arst_n), .ad(ad), .nadv(nadv), .nwe(nwe), .noe(noe),
        .adc_data(adc_data), .signal_in(signal_in), .gain_ctrl(gain_ctrl),
        .adc_clk(adc_clk), .adc_oe_n(adc_oe_n)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns
    end

    task automatic end_failed();
        $display("test failed");
        $fatal(1, "simulation stopped on first failure");
    endtask

    task automatic report_error(input string msg);
        $display("ERROR %0t ns: %s", $time, msg);
        end_failed();
    endtask

    task automatic report_timeout(input string what);
        $display("timed out at %0t ns while %s", $time, what);
        end_failed();
    endtask

    // inputs move 2 ns after the edge
    task automatic step(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic bus_addr(input logic [7:0] addr);
        ad_out = {8'h00, addr};
        ad_en  = 1'b1;
        nadv   = 1'b0;
        step(8);
        nadv = 1'b1; // latch on the rising edge
        step(8);
    endtask

    task automatic bus_write(input logic [7:0] addr, input logic [15:0] data);
        bus_addr(addr);
        ad_out = data;
        nwe    = 1'b0;
        step(8);
        nwe = 1'b1;
        step(8);
        ad_en = 1'b0;
        step(2);
    endtask

    task automatic bus_read(input logic [7:0] addr, output logic [15:0] data);
        bus_addr(addr);
        ad_en = 1'b0; // turnaround
        step(2);
        noe = 1'b0;
        step(8);
        data = ad;
        noe  = 1'b1;
        step(8);
        assert (!$isunknown(data)) else report_error("read data not driven");
    endtask

    // repeated status reads until one bit sets
    task automatic poll_status(input int bit_idx, input int max_polls, input string what);
        logic [15:0] st;
        int          polls;
        polls = 0;
        bus_read(ADDR_STATUS, st);
        while (!st[bit_idx]) begin
            polls++;
            if (polls > max_polls)
                report_timeout(what);
            bus_read(ADDR_STATUS, st);
        end
    endtask

    // cycles until the next adc_clk rise
    task automatic wait_adc_rise(output int cycles);
        logic prev;
        prev = adc_clk;
        step(1);
        cycles = 1;
        while (!(adc_clk && !prev)) begin
            if (cycles >= 500)
                report_timeout("waiting for an adc_clk rise");
            prev = adc_clk;
            step(1);
            cycles++;
        end
    endtask

    // square wave, high for the first half of each period
    initial begin : square_model
        int sq_cnt;
        sq_cnt    = 0;
        signal_in = 1'b0;
        forever begin
            step(1);
            if (sq_period == 0) begin
                sq_cnt    = 0;
                signal_in = 1'b0;
            end else begin
                sq_cnt    = (sq_cnt >= sq_period - 1) ? 0 : sq_cnt + 1;
                signal_in = (sq_cnt < sq_period / 2);
            end
        end
    end

    // adc updates its word after each adc_clk rise
    initial begin : adc_model
        logic clk_prev;
        clk_prev = 1'b0;
        adc_data = 12'd0;
        forever begin
            step(1);
            if (adc_clk && !clk_prev) begin
                if (full_scale)
                    adc_data = (adc_data == 12'd0) ? 12'hfff : 12'd0; // rail to rail
                else
                    adc_data = adc_data + 12'd1; // ramp, wraps at 4095
            end
            clk_prev = adc_clk;
        end
    end

    a_adc_parked: assert property (@(posedge clk) disable iff (!arst_n)
        adc_oe_n |-> !adc_clk)
        else report_error("adc_clk toggling while adc output disabled");

    a_gain_no_rise: assert property (@(posedge clk) disable iff (!arst_n)
        watch_fs |=> gain_ctrl <= $past(gain_ctrl))
        else report_error("gain rose under full-scale input");

    initial begin
        arst_n     = 1'b0;
        ad_out     = 16'h0000;
        ad_en      = 1'b0;
        nadv       = 1'b1;
        nwe        = 1'b1;
        noe        = 1'b1;
        sq_period  = 0;
        full_scale = 1'b0;
        watch_fs   = 1'b0;
        step(10);
        arst_n = 1'b1;
        step(4);

        // reset state
        assert (gain_ctrl == 2'd0) else report_error("gain not 0 after reset");
        assert (adc_oe_n && !adc_clk) else report_error("adc pins not idle after reset");
        assert (ad === 16'hzzzz) else report_error("bus driven after reset");
        bus_read(ADDR_STATUS, rd);
        assert (rd == 16'h0000) else report_error("status not 0 after reset");
        bus_read(ADDR_PERIOD_LO, rd);
        assert (rd == 16'h0000) else report_error("period low not 0 after reset");
        bus_read(ADDR_PERIOD_HI, rd);
        assert (rd == 16'h0000) else report_error("period high not 0 after reset");

        // manual gain 2, auto off
        bus_write(ADDR_CTRL, 16'h0004);
        bus_read(ADDR_CTRL, rd);
        assert (rd == 16'h0004) else report_error("control readback mismatch");
        assert (gain_ctrl == 2'd2) else report_error("gain_ctrl does not follow manual gain");

        // period measurement and divisor
        sq_period = test_period;
        poll_status(st_period_stable, 400, "waiting for period_stable");
        bus_read(ADDR_PERIOD_LO, rd);
        assert (rd == 16'(test_period)) else report_error("period low register wrong");
        bus_read(ADDR_PERIOD_HI, rd);
        assert (rd == 16'h0000) else report_error("period high register wrong");
        bus_read(ADDR_DIVISOR, rd);
        assert (rd == 16'(exp_divisor)) else report_error("divisor register wrong");
        assert (!adc_oe_n) else report_error("adc output not enabled with stable period");
        wait_adc_rise(gap); // align
        repeat (3) begin
            wait_adc_rise(gap);
            assert (gap == exp_divisor) else report_error("adc_clk rise spacing wrong");
        end

        // capture a ramp, keep manual gain 2
        bus_write(ADDR_CTRL, 16'h000c);
        poll_status(st_capture_done, 100, "waiting for capture_done");
        bus_read(ADDR_SAMPLE, prev_sample);
        assert (prev_sample[15:12] == 4'h0) else report_error("sample not zero extended");
        repeat (63) begin
            bus_read(ADDR_SAMPLE, rd);
            assert (rd[15:12] == 4'h0) else report_error("sample not zero extended");
            assert (12'(rd[11:0] - prev_sample[11:0]) == 12'd1)
                else report_error("captured ramp not consecutive");
            prev_sample = rd;
        end

        // automatic gain from manual 3 under full-scale input
        full_scale = 1'b1;
        bus_write(ADDR_CTRL, 16'h0006);
        assert (gain_ctrl == 2'd3) else report_error("manual gain 3 not applied");
        bus_write(ADDR_CTRL, 16'h0007);
        watch_fs = 1'b1;
        gap = 0;
        while (gain_ctrl != 2'd0) begin
            if (gap > 5000)
                report_timeout("waiting for auto gain to reach 0");
            step(1);
            gap++;
        end
        step(1300); // about four windows at gain 0
        bus_read(ADDR_STATUS, rd);
        assert (rd[5:4] == 2'd0) else report_error("status gain not 0");
        assert (rd[st_gain_stable]) else report_error("gain_stable not set at gain 0");
        watch_fs = 1'b0;

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* sdm.f */
design/sdm_pkg.sv
design/bus_regs.sv
design/period_meter.sv
design/sample_clock.sv
design/capture_buffer.sv
design/gain_control.sv
design/sdm_top.sv
tests/sdm_tb.sv
